// ==== tb.f ====
+incdir+include
logic/addsub_pkg.sv
logic/chdr_deframer.sv
logic/addsub.sv
logic/header_rewriter.sv
logic/chdr_framer.sv
logic/noc_block_addsub.sv
verification/noc_block_addsub_sva.sv
verification/tb_noc_block_addsub.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_noc_block_addsub
RTL_TOP    := noc_block_addsub
FILELIST   := tb.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_noc_block_addsub.sv ====
`timescale 1ns/1ns
`include "addsub_config.svh"

module tb_noc_block_addsub;

   localparam int NUM_PKTS    = 40;
   localparam int CYC_PER_PKT = 200;
   localparam int TIMEOUT     = NUM_PKTS * CYC_PER_PKT;
   localparam int MTU_WORDS   = 1 << `ADDSUB_MTU;

   // Wrap corners for I and Q paired by index
   localparam logic [31:0] CORNER_A [4] = '{32'h7fff_8000, 32'hffff_0000,
                                            32'h8000_7fff, 32'h0000_ffff};
   localparam logic [31:0] CORNER_B [4] = '{32'h0001_0001, 32'h0001_0001,
                                            32'h8000_8000, 32'hffff_ffff};

   logic        i_ce_clk;
   logic        i_rst;
   logic [63:0] i_in0_tdata;
   logic        i_in0_tlast;
   logic        i_in0_tvalid;
   logic        o_in0_tready;
   logic [63:0] i_in1_tdata;
   logic        i_in1_tlast;
   logic        i_in1_tvalid;
   logic        o_in1_tready;
   logic [63:0] o_sum_tdata;
   logic        o_sum_tlast;
   logic        o_sum_tvalid;
   logic        i_sum_tready;
   logic [63:0] o_diff_tdata;
   logic        o_diff_tlast;
   logic        o_diff_tvalid;
   logic        i_diff_tready;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   logic [31:0] i_set_data;

   logic [31:0] lfsr = 32'h450e03e9;
   logic [64:0] in0_q [$];
   logic [64:0] in1_q [$];
   logic [64:0] sum_q [$];
   logic [64:0] diff_q [$];
   logic [15:0] dest0_m;
   logic [15:0] dest1_m;
   string       test_name;
   int          cycles;

   noc_block_addsub UUT (.*);

   initial begin
      i_ce_clk = 1'b0;
      forever #4 i_ce_clk = ~i_ce_clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Random source and reference model
   ////////////////////////////////////////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // I and Q each wrap at 16 bits
   function automatic logic [31:0] addsub_ref(input logic [31:0] a, input logic [31:0] b,
                                              input logic sub);
      logic [15:0] i_res;
      logic [15:0] q_res;
      i_res = sub ? a[31:16] - b[31:16] : a[31:16] + b[31:16];
      q_res = sub ? a[15:0] - b[15:0] : a[15:0] + b[15:0];
      return {i_res, q_res};
   endfunction

   // Expected header of one output packet
   function automatic logic [63:0] out_header(input logic [15:0] seq, input logic [15:0] src,
                                              input logic [15:0] dst, input int words);
      return {seq, 16'(8 + 8 * words), src, dst};
   endfunction

   task automatic queue_packet(input int n_samp, input bit corner);
      logic [31:0] a [$];
      logic [31:0] b [$];
      logic [15:0] seq;
      logic [15:0] in_src;
      logic [15:0] in_dst;
      logic [63:0] junk;
      logic        last;
      int          words;
      int          chunk;
      int          k;
      seq          = rand_bits(16);
      in_src       = rand_bits(16);
      in_dst       = rand_bits(16);
      junk[63:32]  = rand_bits(32);
      junk[31:0]   = rand_bits(32);
      for (k = 0; k < n_samp; k++) begin
         a.push_back(corner ? CORNER_A[k % 4] : rand_bits(32));
         b.push_back(corner ? CORNER_B[k % 4] : rand_bits(32));
      end
      // Input 1 header is dropped by the DUT
      in0_q.push_back({1'b0, seq, 16'(8 + 4 * n_samp), in_src, in_dst});
      in1_q.push_back({1'b0, junk});
      words = n_samp / 2;
      for (k = 0; k < words; k++) begin
         in0_q.push_back({k == words - 1, a[2*k], a[2*k+1]});
         in1_q.push_back({k == words - 1, b[2*k], b[2*k+1]});
         if (k % MTU_WORDS == 0) begin
            chunk = (words - k < MTU_WORDS) ? words - k : MTU_WORDS;
            sum_q.push_back({1'b0, out_header(seq, in_dst, dest0_m, chunk)});
            diff_q.push_back({1'b0, out_header(seq, in_dst, dest1_m, chunk)});
         end
         last = (k % MTU_WORDS == MTU_WORDS - 1) || (k == words - 1);
         sum_q.push_back({last, addsub_ref(a[2*k], b[2*k], 1'b0),
                          addsub_ref(a[2*k+1], b[2*k+1], 1'b0)});
         diff_q.push_back({last, addsub_ref(a[2*k], b[2*k], 1'b1),
                           addsub_ref(a[2*k+1], b[2*k+1], 1'b1)});
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Drivers
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge i_ce_clk) begin
      if (i_rst) begin
         i_in0_tvalid <= 1'b0;
         i_in1_tvalid <= 1'b0;
      end else begin
         if (!i_in0_tvalid || o_in0_tready) begin
            i_in0_tvalid <= (in0_q.size() > 0);
            if (in0_q.size() > 0) {i_in0_tlast, i_in0_tdata} <= in0_q.pop_front();
         end
         if (!i_in1_tvalid || o_in1_tready) begin
            i_in1_tvalid <= (in1_q.size() > 0);
            if (in1_q.size() > 0) {i_in1_tlast, i_in1_tdata} <= in1_q.pop_front();
         end
      end
   end

   // Independent back-pressure with ready three times in four
   always @(posedge i_ce_clk) begin
      i_sum_tready  <= (rand_bits(2) != 0);
      i_diff_tready <= (rand_bits(2) != 0);
   end

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(posedge i_ce_clk);
      i_set_stb  <= 1'b1;
      i_set_addr <= addr;
      i_set_data <= data;
      @(posedge i_ce_clk);
      i_set_stb  <= 1'b0;
      if (addr == `ADDSUB_SET_DEST0) dest0_m = data[15:0];
      else if (addr == `ADDSUB_SET_DEST1) dest1_m = data[15:0];
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Checking
   ////////////////////////////////////////////////////////////////////////////

   task automatic stop_on_error();
      $display("STATUS: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_beat(input string port, ref logic [64:0] q [$],
                             input logic [64:0] got);
      logic [64:0] exp;
      assert (q.size() > 0) else begin
         $display("Unexpected extra beat on the %s output during %s", port, test_name);
         stop_on_error();
      end
      exp = q.pop_front();
      assert (got === exp) else begin
         $display("[FAIL] %s %s: expected %h actual %h", test_name, port, exp, got);
         stop_on_error();
      end
   endtask

   always @(posedge i_ce_clk) begin
      if (!i_rst && o_sum_tvalid && i_sum_tready)
         check_beat("sum", sum_q, {o_sum_tlast, o_sum_tdata});
      if (!i_rst && o_diff_tvalid && i_diff_tready)
         check_beat("diff", diff_q, {o_diff_tlast, o_diff_tdata});
   end

   always @(posedge i_ce_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout after %0d cycles in %s with %0d sum and %0d diff beats missing",
                  cycles, test_name, sum_q.size(), diff_q.size());
         $display("STATUS: FAIL");
         $fatal(1, "Timeout");
      end
   end

   task automatic wait_drain();
      while (in0_q.size() > 0 || in1_q.size() > 0 || sum_q.size() > 0 || diff_q.size() > 0)
         @(posedge i_ce_clk);
   endtask

   // Zero length picks a random even length from 2 to 80
   task automatic run_batch(input string name, input int count, input int fixed_len,
                            input bit corner);
      int len;
      int p;
      test_name = name;
      @(negedge i_ce_clk);
      for (p = 0; p < count; p++) begin
         len = fixed_len;
         if (len == 0) len = 2 + 2 * int'(rand_bits(6) % 40);
         queue_packet(len, corner);
      end
      wait_drain();
   endtask

   initial begin
      i_rst         = 1'b1;
      i_in0_tdata   = '0;
      i_in0_tlast   = 1'b0;
      i_in0_tvalid  = 1'b0;
      i_in1_tdata   = '0;
      i_in1_tlast   = 1'b0;
      i_in1_tvalid  = 1'b0;
      i_sum_tready  = 1'b0;
      i_diff_tready = 1'b0;
      i_set_stb     = 1'b0;
      i_set_addr    = '0;
      i_set_data    = '0;
      dest0_m       = 16'd0;
      dest1_m       = 16'd0;
      cycles        = 0;
      test_name     = "reset";
      repeat (2) @(posedge i_ce_clk);
      i_rst <= 1'b0;

      write_setting(8'd0, 32'h0000_1a2b);
      write_setting(8'd1, 32'h0000_3c4d);
      run_batch("corner_wrap", 2, 8, 1'b1);
      run_batch("mtu_exact", 1, 64, 1'b0);
      run_batch("mtu_split", 1, 66, 1'b0);
      run_batch("mtu_split", 1, 80, 1'b0);
      run_batch("mtu_split", 1, 130, 1'b0);
      run_batch("random_a", 12, 0, 1'b0);

      // Only the latest write counts and stray addresses change nothing
      write_setting(8'd0, 32'hffff_5e6f);
      write_setting(8'd0, 32'h0000_7081);
      write_setting(8'd2, 32'h0000_dead);
      write_setting(8'hff, 32'h0000_beef);
      run_batch("bad_addr", 10, 0, 1'b0);

      write_setting(8'd1, 32'h0000_92a3);
      run_batch("random_b", 12, 0, 1'b0);

      if (UUT.u_sva.fail_cnt == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         $display("%0d bound assertion failures during the run", UUT.u_sva.fail_cnt);
         stop_on_error();
      end
   end

endmodule

// ==== verification/noc_block_addsub_sva.sv ====
`timescale 1ns/1ns
`include "addsub_config.svh"

module noc_block_addsub_sva (
   input logic        i_ce_clk,
   input logic        i_rst,
   input logic        i_in0_tready,
   input logic        i_in1_tready,
   input logic [63:0] i_sum_tdata,
   input logic        i_sum_tlast,
   input logic        i_sum_tvalid,
   input logic        i_sum_tready,
   input logic [63:0] i_diff_tdata,
   input logic        i_diff_tlast,
   input logic        i_diff_tvalid,
   input logic        i_diff_tready,
   input logic        i_s0_tvalid,
   input logic        i_s0_tready,
   input logic        i_s0_tlast,
   input logic        i_s1_tlast,
   input logic        i_pop0,
   input logic        i_pop1
);

   localparam int DEPTH = 1 << `ADDSUB_HDR_FIFO_LOG2;

   logic push;
   int   occ0;
   int   occ1;
   int   fail_cnt = 0;

   // Header FIFO fill level seen by each output
   assign push = i_s0_tvalid & i_s0_tready & i_s0_tlast;

   always_ff @(posedge i_ce_clk) begin
      if (i_rst) begin
         occ0 <= 0;
         occ1 <= 0;
      end else begin
         occ0 <= occ0 + int'(push) - int'(i_pop0);
         occ1 <= occ1 + int'(push) - int'(i_pop1);
      end
   end

   sum_hold: assert property (@(posedge i_ce_clk) disable iff (i_rst)
      i_sum_tvalid && !i_sum_tready |=>
         i_sum_tvalid && $stable(i_sum_tdata) && $stable(i_sum_tlast))
      else begin
         $error("sum output changed before it was accepted");
         fail_cnt = fail_cnt + 1;
      end

   diff_hold: assert property (@(posedge i_ce_clk) disable iff (i_rst)
      i_diff_tvalid && !i_diff_tready |=>
         i_diff_tvalid && $stable(i_diff_tdata) && $stable(i_diff_tlast))
      else begin
         $error("diff output changed before it was accepted");
         fail_cnt = fail_cnt + 1;
      end

   fifo_depth: assert property (@(posedge i_ce_clk) disable iff (i_rst)
      occ0 <= DEPTH && occ1 <= DEPTH)
      else begin
         $error("header FIFO overflow");
         fail_cnt = fail_cnt + 1;
      end

   quiet_reset: assert property (@(posedge i_ce_clk)
      i_rst |=> !i_sum_tvalid && !i_diff_tvalid && !i_in0_tready && !i_in1_tready)
      else begin
         $error("valid or ready high right after reset");
         fail_cnt = fail_cnt + 1;
      end

   last_align: assert property (@(posedge i_ce_clk) disable iff (i_rst)
      i_s0_tvalid && i_s0_tready |-> i_s0_tlast == i_s1_tlast)
      else begin
         $error("input streams disagree on packet end");
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind noc_block_addsub noc_block_addsub_sva u_sva (
   .i_ce_clk(i_ce_clk),
   .i_rst(i_rst),
   .i_in0_tready(o_in0_tready),
   .i_in1_tready(o_in1_tready),
   .i_sum_tdata(o_sum_tdata),
   .i_sum_tlast(o_sum_tlast),
   .i_sum_tvalid(o_sum_tvalid),
   .i_sum_tready(i_sum_tready),
   .i_diff_tdata(o_diff_tdata),
   .i_diff_tlast(o_diff_tlast),
   .i_diff_tvalid(o_diff_tvalid),
   .i_diff_tready(i_diff_tready),
   .i_s0_tvalid(s0_tvalid),
   .i_s0_tready(s0_tready),
   .i_s0_tlast(s0_tlast),
   .i_s1_tlast(s1_tlast),
   .i_pop0(hdr_done0),
   .i_pop1(hdr_done1)
);

// ==== logic/noc_block_addsub.sv ====
`timescale 1ns/1ns
`include "addsub_config.svh"

module noc_block_addsub (
   input  logic        i_ce_clk,
   input  logic        i_rst,
   input  logic [63:0] i_in0_tdata,
   input  logic        i_in0_tlast,
   input  logic        i_in0_tvalid,
   output logic        o_in0_tready,
   input  logic [63:0] i_in1_tdata,
   input  logic        i_in1_tlast,
   input  logic        i_in1_tvalid,
   output logic        o_in1_tready,
   output logic [63:0] o_sum_tdata,
   output logic        o_sum_tlast,
   output logic        o_sum_tvalid,
   input  logic        i_sum_tready,
   output logic [63:0] o_diff_tdata,
   output logic        o_diff_tlast,
   output logic        o_diff_tvalid,
   input  logic        i_diff_tready,
   input  logic        i_set_stb,
   input  logic [7:0]  i_set_addr,
   input  logic [31:0] i_set_data
);

   logic [63:0] hdr_in0;
   logic [31:0] s0_tdata;
   logic [31:0] s1_tdata;
   logic        s0_tlast;
   logic        s1_tlast;
   logic        s0_tvalid;
   logic        s1_tvalid;
   logic        s0_tready;
   logic        s1_tready;
   logic [31:0] sum_tdata;
   logic [31:0] diff_tdata;
   logic        sum_tlast;
   logic        diff_tlast;
   logic        sum_tvalid;
   logic        diff_tvalid;
   logic        sum_tready;
   logic        diff_tready;
   logic [63:0] out_hdr0;
   logic [63:0] out_hdr1;
   logic        hdr_done0;
   logic        hdr_done1;

   ////////////////////////////////////////////////////////////////////////////
   // Deframers with the input 1 header dropped
   ////////////////////////////////////////////////////////////////////////////
   chdr_deframer u_deframer0 (
      .i_ce_clk(i_ce_clk), .i_rst(i_rst),
      .i_tdata(i_in0_tdata), .i_tlast(i_in0_tlast), .i_tvalid(i_in0_tvalid),
      .o_tready(o_in0_tready), .o_hdr(hdr_in0),
      .o_tdata(s0_tdata), .o_tlast(s0_tlast), .o_tvalid(s0_tvalid), .i_tready(s0_tready));

   chdr_deframer u_deframer1 (
      .i_ce_clk(i_ce_clk), .i_rst(i_rst),
      .i_tdata(i_in1_tdata), .i_tlast(i_in1_tlast), .i_tvalid(i_in1_tvalid),
      .o_tready(o_in1_tready), .o_hdr(),
      .o_tdata(s1_tdata), .o_tlast(s1_tlast), .o_tvalid(s1_tvalid), .i_tready(s1_tready));

   addsub #(.WIDTH(`ADDSUB_WIDTH)) u_addsub (
      .i_ce_clk(i_ce_clk), .i_rst(i_rst),
      .i_a_tdata(s0_tdata), .i_a_tlast(s0_tlast), .i_a_tvalid(s0_tvalid), .o_a_tready(s0_tready),
      .i_b_tdata(s1_tdata), .i_b_tlast(s1_tlast), .i_b_tvalid(s1_tvalid), .o_b_tready(s1_tready),
      .o_sum_tdata(sum_tdata), .o_sum_tlast(sum_tlast), .o_sum_tvalid(sum_tvalid),
      .i_sum_tready(sum_tready),
      .o_diff_tdata(diff_tdata), .o_diff_tlast(diff_tlast), .o_diff_tvalid(diff_tvalid),
      .i_diff_tready(diff_tready));

   // Push when input 0 hands its last sample to the engine
   header_rewriter u_rewriter (
      .i_ce_clk(i_ce_clk), .i_rst(i_rst),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_hdr_in(hdr_in0), .i_push(s0_tvalid & s0_tready & s0_tlast),
      .i_pop0(hdr_done0), .i_pop1(hdr_done1),
      .o_hdr0(out_hdr0), .o_hdr1(out_hdr1));

   ////////////////////////////////////////////////////////////////////////////
   // Framers
   ////////////////////////////////////////////////////////////////////////////
   chdr_framer u_framer_sum (
      .i_ce_clk(i_ce_clk), .i_rst(i_rst), .i_hdr(out_hdr0),
      .i_tdata(sum_tdata), .i_tlast(sum_tlast), .i_tvalid(sum_tvalid), .o_tready(sum_tready),
      .o_tdata(o_sum_tdata), .o_tlast(o_sum_tlast), .o_tvalid(o_sum_tvalid),
      .i_tready(i_sum_tready), .o_hdr_done(hdr_done0));

   chdr_framer u_framer_diff (
      .i_ce_clk(i_ce_clk), .i_rst(i_rst), .i_hdr(out_hdr1),
      .i_tdata(diff_tdata), .i_tlast(diff_tlast), .i_tvalid(diff_tvalid), .o_tready(diff_tready),
      .o_tdata(o_diff_tdata), .o_tlast(o_diff_tlast), .o_tvalid(o_diff_tvalid),
      .i_tready(i_diff_tready), .o_hdr_done(hdr_done1));

endmodule

// ==== logic/chdr_framer.sv ====
`timescale 1ns/1ns
`include "addsub_config.svh"

module chdr_framer (
   input  logic        i_ce_clk,
   input  logic        i_rst,
   input  logic [63:0] i_hdr,
   input  logic [31:0] i_tdata,
   input  logic        i_tlast,
   input  logic        i_tvalid,
   output logic        o_tready,
   output logic [63:0] o_tdata,
   output logic        o_tlast,
   output logic        o_tvalid,
   input  logic        i_tready,
   output logic        o_hdr_done
);

   localparam int AW    = `ADDSUB_MTU;
   localparam int WORDS = 1 << AW;

   addsub_pkg::frame_state_e state;
   logic [63:0] buffer [WORDS];
   logic [AW:0]   wr_cnt;
   logic [AW-1:0] rd_idx;
   logic        half;
   logic [31:0] high_r;
   logic        pkt_end;
   logic [63:0] hdr_r;
   logic        in_xfer;
   logic        word_in;
   logic        close;
   logic        out_last;
   logic [15:0] len;

   assign o_tready = (state == addsub_pkg::FILL);
   assign in_xfer  = i_tvalid & o_tready;

   // Second sample of a pair completes a word
   assign word_in = in_xfer & half;
   assign close   = word_in & (i_tlast | (wr_cnt == WORDS - 1));

   // Header word counts itself
   assign len      = (16'(wr_cnt) << 3) + 16'd8;
   assign out_last = ({1'b0, rd_idx} == wr_cnt - 1'b1);

   ////////////////////////////////////////////////////////////////////////////
   // Output side
   ////////////////////////////////////////////////////////////////////////////

   assign o_tvalid   = (state != addsub_pkg::FILL);
   assign o_tlast    = (state == addsub_pkg::SEND_PAYLOAD) & out_last;
   assign o_tdata    = (state == addsub_pkg::SEND_HDR) ?
                       {hdr_r[63:48], len, hdr_r[31:0]} : buffer[rd_idx];
   assign o_hdr_done = o_tlast & i_tready & pkt_end;

   always_ff @(posedge i_ce_clk) begin
      if (i_rst) begin
         state   <= addsub_pkg::FILL;
         wr_cnt  <= '0;
         rd_idx  <= '0;
         half    <= 1'b0;
         pkt_end <= 1'b0;
      end else begin
         case (state)
            addsub_pkg::FILL: begin
               if (in_xfer) half <= ~half;
               if (word_in) wr_cnt <= wr_cnt + 1'b1;
               if (close) begin
                  state   <= addsub_pkg::SEND_HDR;
                  pkt_end <= i_tlast;
               end
            end
            addsub_pkg::SEND_HDR: begin
               if (i_tready) begin
                  state  <= addsub_pkg::SEND_PAYLOAD;
                  rd_idx <= '0;
               end
            end
            addsub_pkg::SEND_PAYLOAD: begin
               if (i_tready) begin
                  if (out_last) begin
                     state  <= addsub_pkg::FILL;
                     wr_cnt <= '0;
                  end else begin
                     rd_idx <= rd_idx + 1'b1;
                  end
               end
            end
            default: state <= addsub_pkg::FILL;
         endcase
      end
   end

   // Sample packing and header capture
   always_ff @(posedge i_ce_clk) begin
      if (in_xfer && !half) high_r <= i_tdata;
      if (word_in) buffer[wr_cnt[AW-1:0]] <= {high_r, i_tdata};
      if (close) hdr_r <= i_hdr;
   end

endmodule

// ==== logic/header_rewriter.sv ====
`timescale 1ns/1ns
`include "addsub_config.svh"

module header_rewriter (
   input  logic        i_ce_clk,
   input  logic        i_rst,
   input  logic        i_set_stb,
   input  logic [7:0]  i_set_addr,
   input  logic [31:0] i_set_data,
   input  logic [63:0] i_hdr_in,
   input  logic        i_push,
   input  logic        i_pop0,
   input  logic        i_pop1,
   output logic [63:0] o_hdr0,
   output logic [63:0] o_hdr1
);

   localparam int LOG2  = `ADDSUB_HDR_FIFO_LOG2;
   localparam int DEPTH = 1 << LOG2;

   logic [15:0]   dest0;
   logic [15:0]   dest1;
   logic [63:0]   mem [DEPTH];
   logic [LOG2:0] wr_ptr;
   logic [LOG2:0] rd_ptr0;
   logic [LOG2:0] rd_ptr1;
   logic [63:0]   src0;
   logic [63:0]   src1;

   // Destination registers
   always_ff @(posedge i_ce_clk) begin
      if (i_rst) begin
         dest0 <= 16'd0;
         dest1 <= 16'd0;
      end else if (i_set_stb) begin
         case (addsub_pkg::set_addr_e'(i_set_addr))
            addsub_pkg::SET_DEST0: dest0 <= i_set_data[15:0];
            addsub_pkg::SET_DEST1: dest1 <= i_set_data[15:0];
            default: ;
         endcase
      end
   end

   // One write pointer, one read pointer per output
   always_ff @(posedge i_ce_clk) begin
      if (i_rst) begin
         wr_ptr  <= '0;
         rd_ptr0 <= '0;
         rd_ptr1 <= '0;
      end else begin
         if (i_push) wr_ptr <= wr_ptr + 1'b1;
         if (i_pop0) rd_ptr0 <= rd_ptr0 + 1'b1;
         if (i_pop1) rd_ptr1 <= rd_ptr1 + 1'b1;
      end
   end

   always_ff @(posedge i_ce_clk) begin
      if (i_push) mem[wr_ptr[LOG2-1:0]] <= i_hdr_in;
   end

   // An empty reader is still working on the packet entering the engine,
   // whose header sits in the deframer
   assign src0 = (rd_ptr0 == wr_ptr) ? i_hdr_in : mem[rd_ptr0[LOG2-1:0]];
   assign src1 = (rd_ptr1 == wr_ptr) ? i_hdr_in : mem[rd_ptr1[LOG2-1:0]];

   // Length is left for the framer
   assign o_hdr0 = {src0[63:48], 16'd0, src0[15:0], dest0};
   assign o_hdr1 = {src1[63:48], 16'd0, src1[15:0], dest1};

endmodule

// ==== logic/addsub.sv ====
`timescale 1ns/1ns

module addsub #(
   parameter int WIDTH = 16
) (
   input  logic               i_ce_clk,
   input  logic               i_rst,
   input  logic [2*WIDTH-1:0] i_a_tdata,
   input  logic               i_a_tlast,
   input  logic               i_a_tvalid,
   output logic               o_a_tready,
   input  logic [2*WIDTH-1:0] i_b_tdata,
   input  logic               i_b_tlast,
   input  logic               i_b_tvalid,
   output logic               o_b_tready,
   output logic [2*WIDTH-1:0] o_sum_tdata,
   output logic               o_sum_tlast,
   output logic               o_sum_tvalid,
   input  logic               i_sum_tready,
   output logic [2*WIDTH-1:0] o_diff_tdata,
   output logic               o_diff_tlast,
   output logic               o_diff_tvalid,
   input  logic               i_diff_tready
);

   logic [WIDTH-1:0] a_i;
   logic [WIDTH-1:0] a_q;
   logic [WIDTH-1:0] b_i;
   logic [WIDTH-1:0] b_q;
   logic             take;
   logic             fire;

   assign a_i = i_a_tdata[2*WIDTH-1:WIDTH];
   assign a_q = i_a_tdata[WIDTH-1:0];
   assign b_i = i_b_tdata[2*WIDTH-1:WIDTH];
   assign b_q = i_b_tdata[WIDTH-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // Join
   ////////////////////////////////////////////////////////////////////////////

   // Both result registers must be free, so one stalled output holds both inputs
   assign take = (~o_sum_tvalid | i_sum_tready) & (~o_diff_tvalid | i_diff_tready);

   // Each side waits for its partner before it accepts
   assign o_a_tready = take & i_b_tvalid;
   assign o_b_tready = take & i_a_tvalid;
   assign fire       = take & i_a_tvalid & i_b_tvalid;

   always_ff @(posedge i_ce_clk) begin
      if (i_rst) begin
         o_sum_tvalid  <= 1'b0;
         o_diff_tvalid <= 1'b0;
      end else begin
         if (fire) o_sum_tvalid <= 1'b1;
         else if (i_sum_tready) o_sum_tvalid <= 1'b0;

         if (fire) o_diff_tvalid <= 1'b1;
         else if (i_diff_tready) o_diff_tvalid <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Arithmetic
   ////////////////////////////////////////////////////////////////////////////

   // Component results stay WIDTH bits wide and wrap
   always_ff @(posedge i_ce_clk) begin
      if (fire) begin
         o_sum_tdata  <= {a_i + b_i, a_q + b_q};
         o_diff_tdata <= {a_i - b_i, a_q - b_q};
         o_sum_tlast  <= i_a_tlast;
         o_diff_tlast <= i_a_tlast;
      end
   end

endmodule

// ==== logic/chdr_deframer.sv ====
`timescale 1ns/1ns

module chdr_deframer (
   input  logic        i_ce_clk,
   input  logic        i_rst,
   input  logic [63:0] i_tdata,
   input  logic        i_tlast,
   input  logic        i_tvalid,
   output logic        o_tready,
   output logic [63:0] o_hdr,
   output logic [31:0] o_tdata,
   output logic        o_tlast,
   output logic        o_tvalid,
   input  logic        i_tready
);

   addsub_pkg::deframe_state_e state;
   logic        armed;
   logic        word_vld;
   logic        word_last;
   logic [63:0] word;
   logic        in_xfer;

   assign in_xfer = i_tvalid & o_tready;

   always_comb begin
      o_tready = 1'b0;
      o_tvalid = 1'b0;
      o_tlast  = 1'b0;
      o_tdata  = word[63:32];
      case (state)
         addsub_pkg::HEADER: o_tready = armed;
         addsub_pkg::HIGH: begin
            o_tready = ~word_vld;
            o_tvalid = word_vld;
         end
         addsub_pkg::LOW: begin
            o_tvalid = 1'b1;
            o_tlast  = word_last;
            o_tdata  = word[31:0];
         end
         default: o_tready = 1'b0;
      endcase
   end

   always_ff @(posedge i_ce_clk) begin
      if (i_rst) begin
         state    <= addsub_pkg::HEADER;
         armed    <= 1'b0;
         word_vld <= 1'b0;
      end else begin
         armed <= 1'b1;
         case (state)
            addsub_pkg::HEADER: if (in_xfer) state <= addsub_pkg::HIGH;
            addsub_pkg::HIGH: begin
               if (in_xfer) word_vld <= 1'b1;
               else if (word_vld && i_tready) state <= addsub_pkg::LOW;
            end
            addsub_pkg::LOW: begin
               if (i_tready) begin
                  word_vld <= 1'b0;
                  state    <= word_last ? addsub_pkg::HEADER : addsub_pkg::HIGH;
               end
            end
            default: state <= addsub_pkg::HEADER;
         endcase
      end
   end

   // Header and payload word capture
   always_ff @(posedge i_ce_clk) begin
      if (in_xfer && state == addsub_pkg::HEADER) o_hdr <= i_tdata;
      if (in_xfer && state == addsub_pkg::HIGH) begin
         word      <= i_tdata;
         word_last <= i_tlast;
      end
   end

endmodule

// ==== logic/addsub_pkg.sv ====
`include "addsub_config.svh"

package addsub_pkg;

   // Deframer takes the header word and then two samples per payload word
   typedef enum logic [1:0] {
      HEADER,
      HIGH,
      LOW
   } deframe_state_e;

   // Framer collects samples and then sends header and payload
   typedef enum logic [1:0] {
      FILL,
      SEND_HDR,
      SEND_PAYLOAD
   } frame_state_e;

   // Settings bus opcodes
   typedef enum logic [7:0] {
      SET_DEST0 = `ADDSUB_SET_DEST0,
      SET_DEST1 = `ADDSUB_SET_DEST1
   } set_addr_e;

endpackage

// ==== include/addsub_config.svh ====
`ifndef ADDSUB_CONFIG_SVH
`define ADDSUB_CONFIG_SVH

// Width of one I or Q component
`define ADDSUB_WIDTH 16

// log2 of payload words per output packet
`define ADDSUB_MTU 5

// log2 of the header FIFO depth
`define ADDSUB_HDR_FIFO_LOG2 2

// Settings bus addresses
`define ADDSUB_SET_DEST0 8'd0
`define ADDSUB_SET_DEST1 8'd1

`endif
